/* src/selftrig_settings.svh */
// self-trigger bookkeeping sizes
// channel count and counter widths shared by RTL and testbench
`ifndef SELFTRIG_SETTINGS_SVH
`define SELFTRIG_SETTINGS_SVH

// digitizer channels with their own self-trigger
`define NUM_CHANNELS 5

// global trigger number, wraps silently
`define TRIG_NUM_W 24

// triggers held in one DDR3 half, about 1M
`define SELFTRIG_W 20

// bursts per half, also the width of the
// per-channel burst count and the overflow threshold
`define BURST_W 23

`endif

/* src/trig_types_pkg.sv */
// channel trigger types
// receiver state shared by the receivers, the top level and the testbench
package trig_types_pkg;

  // one accepted trigger per high level of the self-trigger
  typedef enum logic {
    // waiting for an enabled trigger
    TRIG_IDLE = 1'b0,
    // trigger accepted, waiting for the level to fall
    TRIG_HIGH = 1'b1
  } trig_state_t;

endpackage

/* src/buffer_types_pkg.sv */
// DDR3 buffer types
// bank select and swap controller state for the double-buffered store
package buffer_types_pkg;

  // half of the DDR3 store that collects new triggers
  typedef enum logic {
    BANK_LO = 1'b0,
    BANK_HI = 1'b1
  } ddr3_bank_t;

  // swap sequence: announce the change first, flip the bank after
  typedef enum logic [1:0] {
    // ready for a swap request
    SWAP_IDLE     = 2'd0,
    // readout_buffer_changed is high in this state
    SWAP_ANNOUNCE = 2'd1,
    // bank has just flipped, requests still dropped
    SWAP_FLIP     = 2'd2
  } swap_state_t;

endpackage

/* src/channel_trigger_receiver.sv */
// channel trigger receiver
// counts self-triggers and stored bursts per DDR3 half, flags near overflow
`timescale 1ns/1ns
`include "selftrig_settings.svh"

module channel_trigger_receiver (
  input  logic                          clk,
  input  logic                          reset,
  // TTC pulse that zeroes the trigger number
  input  logic                          reset_trig_num,
  // self-trigger level from the channel
  input  logic                          trigger,
  input  logic                          chan_en,
  // half currently collecting triggers
  input  buffer_types_pkg::ddr3_bank_t  ddr3_buffer,
  // one-cycle pulse one cycle ahead of the bank flip
  input  logic                          readout_buffer_changed,
  // bursts per trigger, minus one
  input  logic [`BURST_W-1:0]           burst_count_selftrig,
  input  logic [`BURST_W-1:0]           thres_ddr3_overflow,
  output logic [`TRIG_NUM_W-1:0]        trig_num,
  output logic [`SELFTRIG_W-1:0]        selftriggers_lo,
  output logic [`SELFTRIG_W-1:0]        selftriggers_hi,
  output logic [`BURST_W-1:0]           stored_bursts_lo,
  output logic [`BURST_W-1:0]           stored_bursts_hi,
  output trig_types_pkg::trig_state_t   state,
  // channel overflow warning
  output logic                          almost_full
);

  trig_types_pkg::trig_state_t next_state;
  logic                        accept;
  logic                        lo_active;
  logic                        hi_active;
  logic [`BURST_W-1:0]         burst_step;
  logic [`BURST_W-1:0]         active_bursts;

  // accept only on the first cycle of an enabled high level
  assign accept = (state == trig_types_pkg::TRIG_IDLE) && trigger && chan_en;

  assign lo_active = (ddr3_buffer == buffer_types_pkg::BANK_LO);
  assign hi_active = (ddr3_buffer == buffer_types_pkg::BANK_HI);

  // burst_count_selftrig counts from zero
  assign burst_step = burst_count_selftrig + 1'b1;

  // next state
  always_comb begin
    next_state = state;
    case (state)
      trig_types_pkg::TRIG_IDLE: begin
        if (accept) begin
          next_state = trig_types_pkg::TRIG_HIGH;
        end
      end
      trig_types_pkg::TRIG_HIGH: begin
        // hold until the level drops, a long trigger counts once
        if (!trigger) begin
          next_state = trig_types_pkg::TRIG_IDLE;
        end
      end
      default: next_state = trig_types_pkg::TRIG_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= trig_types_pkg::TRIG_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // global trigger number, TTC reset wins over a coincident trigger
  always_ff @(posedge clk) begin
    if (reset || reset_trig_num) begin
      trig_num <= '0;
    end else if (accept) begin
      trig_num <= trig_num + 1'b1;
    end
  end

  // lo half counters
  // cleared on a buffer change while hi is active, since lo is taken next
  always_ff @(posedge clk) begin
    if (reset) begin
      selftriggers_lo  <= '0;
      stored_bursts_lo <= '0;
    end else if (readout_buffer_changed && hi_active) begin
      selftriggers_lo  <= '0;
      stored_bursts_lo <= '0;
    end else if (accept && lo_active) begin
      selftriggers_lo  <= selftriggers_lo + 1'b1;
      stored_bursts_lo <= stored_bursts_lo + burst_step;
    end
  end

  // hi half counters, mirror of the lo half
  always_ff @(posedge clk) begin
    if (reset) begin
      selftriggers_hi  <= '0;
      stored_bursts_hi <= '0;
    end else if (readout_buffer_changed && lo_active) begin
      selftriggers_hi  <= '0;
      stored_bursts_hi <= '0;
    end else if (accept && hi_active) begin
      selftriggers_hi  <= selftriggers_hi + 1'b1;
      stored_bursts_hi <= stored_bursts_hi + burst_step;
    end
  end

  // overflow warning looks at the half being filled
  assign active_bursts = hi_active ? stored_bursts_hi : stored_bursts_lo;

  // a disabled channel never warns
  assign almost_full = chan_en && (active_bursts > thres_ddr3_overflow);

endmodule

/* src/buffer_swap_control.sv */
// DDR3 buffer swap controller
// announces a buffer change for one cycle, then flips the active half
`timescale 1ns/1ns

module buffer_swap_control (
  input  logic                          clk,
  input  logic                          reset,
  // pulse from the command manager
  input  logic                          swap_request,
  // high for one cycle before the flip
  output logic                          readout_buffer_changed,
  output buffer_types_pkg::ddr3_bank_t  ddr3_buffer
);

  buffer_types_pkg::swap_state_t state;
  buffer_types_pkg::swap_state_t next_state;

  // next state
  // requests outside idle are dropped
  always_comb begin
    next_state = state;
    case (state)
      buffer_types_pkg::SWAP_IDLE: begin
        if (swap_request) begin
          next_state = buffer_types_pkg::SWAP_ANNOUNCE;
        end
      end
      buffer_types_pkg::SWAP_ANNOUNCE: begin
        next_state = buffer_types_pkg::SWAP_FLIP;
      end
      buffer_types_pkg::SWAP_FLIP: begin
        next_state = buffer_types_pkg::SWAP_IDLE;
      end
      // unused encoding
      default: next_state = buffer_types_pkg::SWAP_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= buffer_types_pkg::SWAP_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // receivers clear the half about to be used while the old one is active
  assign readout_buffer_changed = (state == buffer_types_pkg::SWAP_ANNOUNCE);

  // flip at the edge that ends the announce cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      ddr3_buffer <= buffer_types_pkg::BANK_LO;
    end else if (state == buffer_types_pkg::SWAP_ANNOUNCE) begin
      if (ddr3_buffer == buffer_types_pkg::BANK_LO) begin
        ddr3_buffer <= buffer_types_pkg::BANK_HI;
      end else begin
        ddr3_buffer <= buffer_types_pkg::BANK_LO;
      end
    end
  end

endmodule

/* src/selftrigger_top.sv */
// self-trigger bookkeeping top
// per-channel trigger receivers sharing one DDR3 buffer swap controller
`timescale 1ns/1ns
`include "selftrig_settings.svh"

module selftrigger_top (
  input  logic                                          clk,
  input  logic                                          reset,
  // TTC pulse, clears every trigger number
  input  logic                                          reset_trig_num,
  // per-channel levels, channel 0 in bit 0
  input  logic [`NUM_CHANNELS-1:0]                      trigger,
  input  logic [`NUM_CHANNELS-1:0]                      chan_en,
  // per-channel burst counts, channel 0 in the low field
  input  logic [`NUM_CHANNELS*`BURST_W-1:0]             burst_count_selftrig,
  // overflow threshold shared by all channels
  input  logic [`BURST_W-1:0]                           thres_ddr3_overflow,
  // pulse from the command manager
  input  logic                                          swap_request,
  output logic [`NUM_CHANNELS*`TRIG_NUM_W-1:0]          trig_num,
  output logic [`NUM_CHANNELS*`SELFTRIG_W-1:0]          selftriggers_lo,
  output logic [`NUM_CHANNELS*`SELFTRIG_W-1:0]          selftriggers_hi,
  output logic [`NUM_CHANNELS*`BURST_W-1:0]             stored_bursts_lo,
  output logic [`NUM_CHANNELS*`BURST_W-1:0]             stored_bursts_hi,
  output trig_types_pkg::trig_state_t [`NUM_CHANNELS-1:0] trig_state,
  output buffer_types_pkg::ddr3_bank_t                  ddr3_buffer,
  output logic                                          readout_buffer_changed,
  // any enabled channel close to filling its half
  output logic                                          ddr3_almost_full
);

  // per-channel overflow warnings before the OR
  logic [`NUM_CHANNELS-1:0] chan_almost_full;

  // one swap controller drives every receiver
  buffer_swap_control i_swap (
    .clk                    (clk),
    .reset                  (reset),
    .swap_request           (swap_request),
    .readout_buffer_changed (readout_buffer_changed),
    .ddr3_buffer            (ddr3_buffer)
  );

  // channels run independently of each other
  // each gets its own slice of the flattened buses
  for (genvar ch = 0; ch < `NUM_CHANNELS; ch++) begin : g_chan
    channel_trigger_receiver i_rx (
      .clk                    (clk),
      .reset                  (reset),
      .reset_trig_num         (reset_trig_num),
      .trigger                (trigger[ch]),
      .chan_en                (chan_en[ch]),
      .ddr3_buffer            (ddr3_buffer),
      .readout_buffer_changed (readout_buffer_changed),
      .burst_count_selftrig   (burst_count_selftrig[ch*`BURST_W +: `BURST_W]),
      .thres_ddr3_overflow    (thres_ddr3_overflow),
      .trig_num               (trig_num[ch*`TRIG_NUM_W +: `TRIG_NUM_W]),
      .selftriggers_lo        (selftriggers_lo[ch*`SELFTRIG_W +: `SELFTRIG_W]),
      .selftriggers_hi        (selftriggers_hi[ch*`SELFTRIG_W +: `SELFTRIG_W]),
      .stored_bursts_lo       (stored_bursts_lo[ch*`BURST_W +: `BURST_W]),
      .stored_bursts_hi       (stored_bursts_hi[ch*`BURST_W +: `BURST_W]),
      .state                  (trig_state[ch]),
      .almost_full            (chan_almost_full[ch])
    );
  end

  // advisory only, nothing is throttled here
  assign ddr3_almost_full = |chan_almost_full;

endmodule

/* dv/selftrigger_tb.sv */
// self-trigger bookkeeping testbench
// runs the commands of the data file against the DUT and checks the counters
`timescale 1ns/1ns
`include "selftrig_settings.svh"

module selftrigger_tb;

  localparam int    CLK_PERIOD      = 20;
  localparam int    DRIVE_DELAY     = 2;
  localparam int    CYCLES_PER_LINE = 20;
  localparam string DATA_FILE       = "dv/selftrigger_testdata.txt";

  logic                                          clk;
  logic                                          reset;
  logic                                          reset_trig_num;
  logic [`NUM_CHANNELS-1:0]                      trigger;
  logic [`NUM_CHANNELS-1:0]                      chan_en;
  logic [`NUM_CHANNELS*`BURST_W-1:0]             burst_count_selftrig;
  logic [`BURST_W-1:0]                           thres_ddr3_overflow;
  logic                                          swap_request;
  logic [`NUM_CHANNELS*`TRIG_NUM_W-1:0]          trig_num;
  logic [`NUM_CHANNELS*`SELFTRIG_W-1:0]          selftriggers_lo;
  logic [`NUM_CHANNELS*`SELFTRIG_W-1:0]          selftriggers_hi;
  logic [`NUM_CHANNELS*`BURST_W-1:0]             stored_bursts_lo;
  logic [`NUM_CHANNELS*`BURST_W-1:0]             stored_bursts_hi;
  trig_types_pkg::trig_state_t [`NUM_CHANNELS-1:0] trig_state;
  buffer_types_pkg::ddr3_bank_t                  ddr3_buffer;
  logic                                          readout_buffer_changed;
  logic                                          ddr3_almost_full;

  // name of the test being run, shown in error lines
  string test_name = "none";
  // file length, sizes the watchdog
  int    num_lines = 0;

  selftrigger_top i_dut (
    .clk                    (clk),
    .reset                  (reset),
    .reset_trig_num         (reset_trig_num),
    .trigger                (trigger),
    .chan_en                (chan_en),
    .burst_count_selftrig   (burst_count_selftrig),
    .thres_ddr3_overflow    (thres_ddr3_overflow),
    .swap_request           (swap_request),
    .trig_num               (trig_num),
    .selftriggers_lo        (selftriggers_lo),
    .selftriggers_hi        (selftriggers_hi),
    .stored_bursts_lo       (stored_bursts_lo),
    .stored_bursts_hi       (stored_bursts_hi),
    .trig_state             (trig_state),
    .ddr3_buffer            (ddr3_buffer),
    .readout_buffer_changed (readout_buffer_changed),
    .ddr3_almost_full       (ddr3_almost_full)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // watchdog, started once the file length is known
  initial begin
    longint limit_ns;
    wait (num_lines > 0);
    // a few extra cycles cover reset
    limit_ns = longint'(num_lines + 4) * CYCLES_PER_LINE * CLK_PERIOD;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  // step n edges, then move to the drive point
  task automatic next_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error: test %s, %s expected %0d actual %0d",
               test_name, field, expected, actual);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // scanned field count must match the command
  task automatic expect_fields(input int rc, input int n, input string cmd);
    assert (rc == n) else begin
      $display("data file has a malformed %s command in test %s", cmd, test_name);
      $display("tests failed");
      $fatal(1, "bad data file");
    end
  endtask

  task automatic check_channel(input int ch, input int exp_tn, input int exp_lo,
                               input int exp_hi, input int exp_blo, input int exp_bhi,
                               input int exp_bank, input int exp_af);
    string where;
    where = $sformatf("channel %0d", ch);
    check_value({where, " trig_num"}, exp_tn,
                trig_num[ch*`TRIG_NUM_W +: `TRIG_NUM_W]);
    check_value({where, " selftriggers_lo"}, exp_lo,
                selftriggers_lo[ch*`SELFTRIG_W +: `SELFTRIG_W]);
    check_value({where, " selftriggers_hi"}, exp_hi,
                selftriggers_hi[ch*`SELFTRIG_W +: `SELFTRIG_W]);
    check_value({where, " stored_bursts_lo"}, exp_blo,
                stored_bursts_lo[ch*`BURST_W +: `BURST_W]);
    check_value({where, " stored_bursts_hi"}, exp_bhi,
                stored_bursts_hi[ch*`BURST_W +: `BURST_W]);
    check_value({where, " ddr3_buffer"}, exp_bank, ddr3_buffer);
    check_value({where, " ddr3_almost_full"}, exp_af, ddr3_almost_full);
    // every command ends with the trigger low, so the receiver is back in idle
    check_value({where, " trig_state"}, trig_types_pkg::TRIG_IDLE, trig_state[ch]);
    // no swap in progress between commands
    check_value({where, " readout_buffer_changed"}, 0, readout_buffer_changed);
  endtask

  initial begin
    int          fd;
    int          rc;
    int          ch;
    int          hold;
    int          value;
    int          line_count;
    int          exp_tn, exp_lo, exp_hi, exp_blo, exp_bhi, exp_bank, exp_af;
    logic [31:0] mask;
    string       cmd;
    string       line;
    // bank the DUT should be filling, toggled per swap
    buffer_types_pkg::ddr3_bank_t bank_now;
    reset                = 1'b1;
    reset_trig_num       = 1'b0;
    trigger              = '0;
    chan_en              = '0;
    burst_count_selftrig = '0;
    // highest threshold keeps the warning off until a test lowers it
    thres_ddr3_overflow  = '1;
    swap_request         = 1'b0;
    bank_now             = buffer_types_pkg::BANK_LO;
    line_count           = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the data file %s", DATA_FILE);
      $display("tests failed");
      $fatal(1, "no data file");
    end
    while ($fgets(line, fd) > 0) begin
      line_count++;
    end
    $fclose(fd);
    if (line_count == 0) begin
      $display("the data file %s is empty", DATA_FILE);
      $display("tests failed");
      $fatal(1, "empty data file");
    end
    num_lines = line_count;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    fd = $fopen(DATA_FILE, "r");
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd.substr(0, 0) == "#") begin
        // comment, skip the rest of the line
        rc = $fgets(line, fd);
      end else if (cmd == "test") begin
        rc = $fscanf(fd, "%s", test_name);
        expect_fields(rc, 1, cmd);
      end else if (cmd == "trig") begin
        rc = $fscanf(fd, "%b %d", mask, hold);
        expect_fields(rc, 2, cmd);
        trigger = mask[`NUM_CHANNELS-1:0];
        next_cycles(hold);
        trigger = '0;
        next_cycles(2);
      end else if (cmd == "en") begin
        rc = $fscanf(fd, "%b", mask);
        expect_fields(rc, 1, cmd);
        chan_en = mask[`NUM_CHANNELS-1:0];
        next_cycles(1);
      end else if (cmd == "burst") begin
        rc = $fscanf(fd, "%d %d", ch, value);
        expect_fields(rc, 2, cmd);
        burst_count_selftrig[ch*`BURST_W +: `BURST_W] = value;
        next_cycles(1);
      end else if (cmd == "thres") begin
        rc = $fscanf(fd, "%d", value);
        expect_fields(rc, 1, cmd);
        thres_ddr3_overflow = value;
        next_cycles(1);
      end else if (cmd == "swap") begin
        swap_request = 1'b1;
        next_cycles(1);
        swap_request = 1'b0;
        // announce cycle, the old bank is still active
        check_value("readout_buffer_changed in announce", 1, readout_buffer_changed);
        check_value("ddr3_buffer in announce", bank_now, ddr3_buffer);
        next_cycles(1);
        // pulse over, bank flipped
        bank_now = (bank_now == buffer_types_pkg::BANK_LO) ?
                   buffer_types_pkg::BANK_HI : buffer_types_pkg::BANK_LO;
        check_value("readout_buffer_changed after pulse", 0, readout_buffer_changed);
        check_value("ddr3_buffer after flip", bank_now, ddr3_buffer);
        next_cycles(2);
      end else if (cmd == "rstnum") begin
        reset_trig_num = 1'b1;
        next_cycles(1);
        reset_trig_num = 1'b0;
        next_cycles(1);
      end else if (cmd == "check") begin
        rc = $fscanf(fd, "%d %d %d %d %d %d %d %d", ch, exp_tn, exp_lo, exp_hi,
                     exp_blo, exp_bhi, exp_bank, exp_af);
        expect_fields(rc, 8, cmd);
        check_channel(ch, exp_tn, exp_lo, exp_hi, exp_blo, exp_bhi, exp_bank, exp_af);
      end else begin
        $display("data file holds an unknown command %s", cmd);
        $display("tests failed");
        $fatal(1, "bad data file");
      end
    end
    $fclose(fd);
    $display("all tests passed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+src
src/trig_types_pkg.sv
src/buffer_types_pkg.sv
src/channel_trigger_receiver.sv
src/buffer_swap_control.sv
src/selftrigger_top.sv
dv/selftrigger_tb.sv

/* dv/selftrigger_testdata.txt */
# test <name> | trig <mask> <cycles> | en <mask> | burst <ch> <n> | thres <n> | swap | rstnum
# check <ch> <trig_num> <lo> <hi> <bursts_lo> <bursts_hi> <bank> <almost_full>, masks ch0 right
test reset_state
check 0 0 0 0 0 0 0 0
check 4 0 0 0 0 0 0 0
test single_trigger
en 00001
burst 0 3
trig 00001 5
check 0 1 1 0 4 0 0 0
trig 00001 1
check 0 2 2 0 8 0 0 0
test disabled_channel
trig 00010 4
check 1 0 0 0 0 0 0 0
check 0 2 2 0 8 0 0 0
test swap_to_hi
swap
check 0 2 2 0 8 0 1 0
en 00011
burst 1 9
trig 00011 3
check 0 3 2 1 8 4 1 0
check 1 1 0 1 0 10 1 0
test swap_back_to_lo
swap
check 0 3 0 1 0 4 0 0
check 1 1 0 1 0 10 0 0
trig 00001 2
check 0 4 1 1 4 4 0 0
test trig_num_reset
rstnum
check 0 0 1 1 4 4 0 0
check 1 0 0 1 0 10 0 0
trig 00011 1
check 0 1 2 1 8 4 0 0
check 1 1 1 1 10 10 0 0
test almost_full
thres 9
check 1 1 1 1 10 10 0 1
en 00001
check 1 1 1 1 10 10 0 0
en 00011
check 0 1 2 1 8 4 0 1
swap
check 0 1 2 0 8 0 1 0
check 1 1 1 0 10 0 1 0
test independent_channels
en 11111
burst 2 0
burst 3 5
burst 4 100
thres 8388607
trig 11100 2
trig 01001 3
trig 10110 1
check 0 2 2 1 8 4 1 0
check 1 2 1 1 10 10 1 0
check 2 2 0 2 0 2 1 0
check 3 2 0 2 0 12 1 0
check 4 2 0 2 0 202 1 0
